// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       = tb_lsu_ahb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } $$0 == "ALL CHECKS PASSED" { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tb_lsu_ahb.sv
`timescale 1ns/100ps

module tb_lsu_ahb
    import lsu_bus_pkg::*;
();

    localparam int WAIT_STATES = 1;
    localparam int DEPTH_WORDS = 256;
    localparam int MEM_BYTES   = 4 * DEPTH_WORDS;
    localparam int MA_W        = $clog2(MEM_BYTES);
    localparam int RST_CYC     = 5;
    localparam int N_WORD      = 16;
    localparam int HOLD_CYC    = 6;
    // worst case per access, idle cycle after it included
    localparam int ACC_CYC     = 2 * WAIT_STATES + 5;
    localparam int N_ACC       = 2 * N_WORD + 30 + 3 + 3;
    localparam int TEST_CYC    = RST_CYC + N_ACC * ACC_CYC + HOLD_CYC + WAIT_STATES + 8;
    localparam int TIMEOUT_CYC = 2 * TEST_CYC;

    logic               clk;
    logic               rst_n;
    lsu_req_t           lsu_req;
    logic               if_stallreq;
    logic               hold;
    logic [31:0]        rdata;
    logic [STALL_W-1:0] stall;

    // byte wide reference memory, little endian
    logic [7:0]         ref_mem [MEM_BYTES];
    logic               stall_chk;
    logic               hold_chk;
    logic [31:0]        exp_rdata;
    logic [STALL_W-1:0] exp_stall;
    int                 err_cnt  = 0;
    int                 test_err = 0;
    int                 test_num = 0;
    int                 cycles   = 0;
    integer             seed     = 32'h2797;

    lsu_ahb_top #(
        .DEPTH_WORDS (DEPTH_WORDS),
        .WAIT_STATES (WAIT_STATES)
    ) lsu_ahb_top_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .lsu_req_i     (lsu_req),
        .if_stallreq_i (if_stallreq),
        .hold_i        (hold),
        .rdata_o       (rdata),
        .stall_o       (stall)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    assert property (@(posedge clk) !rst_n |-> stall == '0)
        else begin
            $display("Fail stall_o in reset got %h expected %h", $sampled(stall), 6'h00);
            err_cnt = err_cnt + 1;
        end

    assert property (@(posedge clk) !rst_n |-> rdata == 32'h0)
        else begin
            $display("Fail rdata_o in reset got %h expected %h", $sampled(rdata), 32'h0);
            err_cnt = err_cnt + 1;
        end

    // load result, taken where the memory stage is released
    assert property (@(posedge clk) lsu_req.re && !stall[MEM_STAGE] |-> rdata == exp_rdata)
        else begin
            $display("Fail rdata_o got %h expected %h", $sampled(rdata), exp_rdata);
            err_cnt = err_cnt + 1;
        end

    assert property (@(posedge clk) stall_chk |-> stall == exp_stall)
        else begin
            $display("Fail stall_o got %h expected %h", $sampled(stall), exp_stall);
            err_cnt = err_cnt + 1;
        end

    assert property (@(posedge clk) hold_chk |-> rdata == exp_rdata)
        else begin
            $display("Fail rdata_o under hold got %h expected %h", $sampled(rdata), exp_rdata);
            err_cnt = err_cnt + 1;
        end

    function automatic logic [31:0] load_model(input logic [31:0] addr, input lsu_op_e op);
        logic [MA_W-1:0] a;
        logic [7:0]      b;
        logic [15:0]     h;
        logic [31:0]     w;
        a = addr[MA_W-1:0];
        b = ref_mem[a];
        h = {ref_mem[{a[MA_W-1:1], 1'b1}], ref_mem[{a[MA_W-1:1], 1'b0}]};
        w = {ref_mem[{a[MA_W-1:2], 2'd3}], ref_mem[{a[MA_W-1:2], 2'd2}],
             ref_mem[{a[MA_W-1:2], 2'd1}], ref_mem[{a[MA_W-1:2], 2'd0}]};
        case (op)
            LB:      return {{24{b[7]}}, b};
            LBU:     return {24'h0, b};
            LH:      return {{16{h[15]}}, h};
            LHU:     return {16'h0, h};
            default: return w;
        endcase
    endfunction

    task automatic store_model(input logic [31:0] addr, input logic [31:0] data,
                               input lsu_op_e op);
        logic [MA_W-1:0] a;
        a = addr[MA_W-1:0];
        case (op)
            SB: begin
                ref_mem[a] = data[7:0];
            end
            SH: begin
                ref_mem[{a[MA_W-1:1], 1'b0}] = data[7:0];
                ref_mem[{a[MA_W-1:1], 1'b1}] = data[15:8];
            end
            default: begin
                for (int i = 0; i < 4; i++) begin
                    ref_mem[{a[MA_W-1:2], 2'(i)}] = data[8*i +: 8];
                end
            end
        endcase
    endtask

    // called on a falling edge
    task automatic drive_req(input logic re, input logic we, input lsu_op_e op,
                             input logic [31:0] addr, input logic [31:0] wdata);
        lsu_req.re    = re;
        lsu_req.we    = we;
        lsu_req.op    = op;
        lsu_req.addr  = addr;
        lsu_req.wdata = wdata;
        exp_rdata     = re ? load_model(addr, op) : 32'h0;
    endtask

    // request stays put until the memory stage is no longer stalled
    task automatic finish_req();
        do begin
            @(posedge clk);
        end while (stall[MEM_STAGE]);
        if (lsu_req.we) begin
            store_model(lsu_req.addr, lsu_req.wdata, lsu_req.op);
        end
        @(negedge clk);
        lsu_req = '0;
    endtask

    task automatic access(input logic re, input logic we, input lsu_op_e op,
                          input logic [31:0] addr, input logic [31:0] wdata);
        @(negedge clk);
        drive_req(re, we, op, addr, wdata);
        finish_req();
    endtask

    // word background, one narrow store, both loads, then the whole word again
    task automatic subword(input lsu_op_e st_op, input lsu_op_e ld_s, input lsu_op_e ld_u,
                           input int off);
        logic [31:0] base;
        logic [31:0] data;
        base = $random(seed) & 32'h3fc;
        data = $random(seed);
        access(1'b0, 1'b1, SW, base, data);
        data     = $random(seed);
        // sign bit follows the lane offset so both extensions show up
        data[7]  = off[0];
        data[15] = off[1];
        access(1'b0, 1'b1, st_op, base + 32'(off), data);
        access(1'b1, 1'b0, ld_s, base + 32'(off), 32'h0);
        access(1'b1, 1'b0, ld_u, base + 32'(off), 32'h0);
        access(1'b1, 1'b0, LW, base, 32'h0);
    endtask

    task automatic report_test(input string name);
        test_num = test_num + 1;
        $display("test %0d %s: %0d errors", test_num, name, err_cnt - test_err);
        test_err = err_cnt;
    endtask

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        rst_n       = 1'b0;
        lsu_req     = '0;
        if_stallreq = 1'b0;
        hold        = 1'b0;
        stall_chk   = 1'b0;
        hold_chk    = 1'b0;
        exp_rdata   = 32'h0;
        exp_stall   = '0;
        repeat (RST_CYC) @(negedge clk);
        rst_n = 1'b1;
        report_test("reset");

        for (int i = 0; i < N_WORD; i++) begin
            addr = $random(seed) & 32'h3fc;
            data = $random(seed);
            access(1'b0, 1'b1, SW, addr, data);
            access(1'b1, 1'b0, LW, addr, 32'h0);
        end
        report_test("word store and load");

        for (int off = 0; off < 4; off++) begin
            subword(SB, LB, LBU, off);
        end
        for (int off = 0; off < 4; off += 2) begin
            subword(SH, LH, LHU, off);
        end
        report_test("sub-word access");

        addr = $random(seed) & 32'h3fc;
        data = $random(seed);
        access(1'b0, 1'b1, SW, addr, data);
        data = $random(seed);
        access(1'b1, 1'b1, LW, addr, data);
        access(1'b1, 1'b0, LW, addr, 32'h0);
        report_test("read then write");

        @(negedge clk);
        if_stallreq = 1'b1;
        exp_stall   = 6'h03;
        stall_chk   = 1'b1;
        @(negedge clk);
        if_stallreq = 1'b0;
        exp_stall   = 6'h1f;
        drive_req(1'b1, 1'b0, LW, addr, 32'h0);
        @(negedge clk);
        stall_chk = 1'b0;
        finish_req();
        hold      = 1'b1;
        exp_stall = '1;
        stall_chk = 1'b1;
        @(negedge clk);
        hold      = 1'b0;
        stall_chk = 1'b0;
        report_test("stall vector");

        // a different word, so the held value differs from the last load
        addr = addr ^ 32'h10;
        data = $random(seed);
        access(1'b0, 1'b1, SW, addr, data);
        @(negedge clk);
        hold      = 1'b1;
        stall_chk = 1'b1;
        drive_req(1'b1, 1'b0, LW, addr, 32'h0);
        // read data is in after 2+W edges
        repeat (WAIT_STATES + 2) @(negedge clk);
        hold_chk = 1'b1;
        repeat (HOLD_CYC) @(negedge clk);
        hold_chk  = 1'b0;
        stall_chk = 1'b0;
        hold      = 1'b0;
        finish_req();
        report_test("hold");

        $display("tests %0d, errors %0d", test_num, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        while (cycles < TIMEOUT_CYC) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("timeout after %0d cycles, a request never completed", cycles);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: logic/ahb_sram_slave.sv
`timescale 1ns/100ps

module ahb_sram_slave import lsu_bus_pkg::*; #(
    parameter int DEPTH_WORDS = 256,
    parameter int WAIT_STATES = 1
) (
    input  logic        clk,
    input  logic        rst_n,
    input  ahb_mst_t    ahb_i,
    output logic [31:0] hrdata_o,
    output logic        hready_o
);

    // depth is a power of two so the word index wraps
    localparam int IDX_W = (DEPTH_WORDS > 1) ? $clog2(DEPTH_WORDS) : 1;
    localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

    logic [31:0]      mem [DEPTH_WORDS];
    logic             pend_q;
    logic [CNT_W-1:0] cnt_q;
    logic             write_q;
    logic [2:0]       size_q;
    logic [1:0]       lane_q;
    logic [IDX_W-1:0] idx_q;
    logic             start;
    logic             last;
    logic [3:0]       be;

    assign start    = hready_o && ahb_i.hsel && (ahb_i.htrans == HTRANS_NONSEQ);
    assign last     = pend_q && (cnt_q == '0);
    assign hready_o = !pend_q || last;

    // data phase tracking and wait counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_q <= 1'b0;
            cnt_q  <= '0;
        end else if (start) begin
            pend_q <= 1'b1;
            cnt_q  <= CNT_W'(WAIT_STATES);
        end else if (last) begin
            pend_q <= 1'b0;
        end else if (pend_q) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // address phase latch
    always_ff @(posedge clk) begin
        if (start) begin
            write_q <= ahb_i.hwrite;
            size_q  <= ahb_i.hsize;
            lane_q  <= ahb_i.haddr[1:0];
            idx_q   <= ahb_i.haddr[IDX_W+1:2];
        end
    end

    // byte enables from size and low address
    always_comb begin
        case (size_q)
            HSIZE_BYTE: be = 4'b0001 << lane_q;
            HSIZE_HALF: be = lane_q[1] ? 4'b1100 : 4'b0011;
            default:    be = 4'b1111;
        endcase
    end

    always_ff @(posedge clk) begin
        if (last && write_q) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    mem[idx_q][8*i +: 8] <= ahb_i.hwdata[8*i +: 8];
                end
            end
        end
    end

    assign hrdata_o = (last && !write_q) ? mem[idx_q] : 32'h0;

endmodule

// File: logic/ls_ahb_master.sv
`timescale 1ns/100ps

module ls_ahb_master import lsu_bus_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  ahb_req_t           bus_req_i,
    input  logic [STALL_W-1:0] stall_i,
    input  logic               hready_i,
    input  logic [31:0]        hrdata_i,
    output ahb_mst_t           ahb_o,
    output logic [31:0]        rdata_raw_o,
    output logic               stallreq_o
);

    ahb_state_e  state_q;
    ahb_state_e  state_d;
    logic        req_any;
    logic        rd_done;
    logic        mem_stall;
    logic        wr_start;
    logic        addr_phase;
    logic [31:0] hwdata_q;
    logic [31:0] rdata_q;

    assign req_any   = bus_req_i.re | bus_req_i.we;
    assign rd_done   = (state_q == READ) && hready_i;
    assign mem_stall = stall_i[MEM_STAGE];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // read:            IDLE -> READ -> READ_WAIT -> IDLE
    // write:           IDLE -> WRITE -> IDLE
    // read then write: IDLE -> READ -> WRITE -> IDLE
    // IDLE and READ ignore the stall, otherwise our own stallreq would lock us up
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (bus_req_i.re) begin
                    state_d = READ;
                end else if (bus_req_i.we) begin
                    state_d = WRITE;
                end
            end
            READ: begin
                if (hready_i) begin
                    state_d = bus_req_i.we ? WRITE : READ_WAIT;
                end
            end
            WRITE: begin
                if (hready_i && !mem_stall) begin
                    state_d = IDLE;
                end
            end
            READ_WAIT: begin
                if (!mem_stall) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // write address phase, from IDLE or straight out of a finished read
    assign wr_start = (state_q != WRITE) && (state_d == WRITE);

    // address phase goes out in the same cycle the request is seen
    assign addr_phase = ((state_q == IDLE) && req_any) || wr_start;

    // data for the write data phase, held through wait states
    always_ff @(posedge clk) begin
        if (wr_start) begin
            hwdata_q <= bus_req_i.wdata;
        end
    end

    // read data captured when the data phase completes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_q <= 32'h0;
        end else if (rd_done) begin
            rdata_q <= hrdata_i;
        end
    end

    always_comb begin
        ahb_o.hsel      = req_any;
        ahb_o.htrans    = addr_phase ? HTRANS_NONSEQ : HTRANS_IDLE;
        ahb_o.haddr     = bus_req_i.addr;
        ahb_o.hwrite    = wr_start;
        ahb_o.hsize     = bus_req_i.size;
        ahb_o.hburst    = HBURST_SINGLE;
        ahb_o.hprot     = HPROT_DATA;
        ahb_o.hmastlock = 1'b0;
        ahb_o.hwdata    = hwdata_q;
    end

    assign rdata_raw_o = rdata_q;

    // no stall term here, keeps the path to the stall controller loop free
    assign stallreq_o = ((state_q == IDLE) && req_any) || !hready_i || rd_done;

endmodule

// File: logic/lsu_ahb_top.sv
`timescale 1ns/100ps

module lsu_ahb_top import lsu_bus_pkg::*; #(
    parameter int DEPTH_WORDS = 256,
    parameter int WAIT_STATES = 1
) (
    input  logic               clk,
    input  logic               rst_n,
    input  lsu_req_t           lsu_req_i,
    input  logic               if_stallreq_i,
    input  logic               hold_i,
    output logic [31:0]        rdata_o,
    output logic [STALL_W-1:0] stall_o
);

    ahb_req_t    bus_req;
    ahb_mst_t    ahb_bus;
    logic [31:0] hrdata;
    logic [31:0] rdata_raw;
    logic        hready;
    logic        mem_stallreq;

    lsu_align lsu_align_inst (
        .req_i       (lsu_req_i),
        .rdata_raw_i (rdata_raw),
        .bus_req_o   (bus_req),
        .rdata_o     (rdata_o)
    );

    ls_ahb_master ls_ahb_master_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus_req_i   (bus_req),
        .stall_i     (stall_o),
        .hready_i    (hready),
        .hrdata_i    (hrdata),
        .ahb_o       (ahb_bus),
        .rdata_raw_o (rdata_raw),
        .stallreq_o  (mem_stallreq)
    );

    ahb_sram_slave #(
        .DEPTH_WORDS (DEPTH_WORDS),
        .WAIT_STATES (WAIT_STATES)
    ) ahb_sram_slave_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .ahb_i    (ahb_bus),
        .hrdata_o (hrdata),
        .hready_o (hready)
    );

    mem_stall_ctrl mem_stall_ctrl_inst (
        .mem_stallreq_i (mem_stallreq),
        .if_stallreq_i  (if_stallreq_i),
        .hold_i         (hold_i),
        .stall_o        (stall_o)
    );

endmodule

// File: logic/lsu_align.sv
`timescale 1ns/100ps

module lsu_align import lsu_bus_pkg::*; (
    input  lsu_req_t    req_i,
    input  logic [31:0] rdata_raw_i,
    output ahb_req_t    bus_req_o,
    output logic [31:0] rdata_o
);

    logic [7:0]  load_byte;
    logic [15:0] load_half;

    // store side, size from the opcode and data copied to every lane
    always_comb begin
        bus_req_o.re   = req_i.re;
        bus_req_o.we   = req_i.we;
        bus_req_o.addr = req_i.addr;
        case (req_i.op)
            LB, LBU, SB: begin
                bus_req_o.size  = HSIZE_BYTE;
                bus_req_o.wdata = {4{req_i.wdata[7:0]}};
            end
            LH, LHU, SH: begin
                bus_req_o.size  = HSIZE_HALF;
                bus_req_o.wdata = {2{req_i.wdata[15:0]}};
            end
            default: begin
                bus_req_o.size  = HSIZE_WORD;
                bus_req_o.wdata = req_i.wdata;
            end
        endcase
    end

    // lane select for loads
    always_comb begin
        case (req_i.addr[1:0])
            2'd0:    load_byte = rdata_raw_i[7:0];
            2'd1:    load_byte = rdata_raw_i[15:8];
            2'd2:    load_byte = rdata_raw_i[23:16];
            default: load_byte = rdata_raw_i[31:24];
        endcase
        if (req_i.addr[1]) begin
            load_half = rdata_raw_i[31:16];
        end else begin
            load_half = rdata_raw_i[15:0];
        end
    end

    // sign or zero extension
    always_comb begin
        case (req_i.op)
            LB: begin
                rdata_o = {{24{load_byte[7]}}, load_byte};
            end
            LBU: begin
                rdata_o = {24'h0, load_byte};
            end
            LH: begin
                rdata_o = {{16{load_half[15]}}, load_half};
            end
            LHU: begin
                rdata_o = {16'h0, load_half};
            end
            default: begin
                rdata_o = rdata_raw_i;
            end
        endcase
    end

endmodule

// File: logic/lsu_bus_pkg.sv
package lsu_bus_pkg;

    // pipeline stall vector, one bit per stage
    localparam int STALL_W     = 6;
    localparam int MEM_STAGE   = 4;
    localparam int FETCH_STAGE = 1;

    // htrans encodings, only single transfers are issued
    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

    localparam logic [2:0] HBURST_SINGLE = 3'b000;

    localparam logic [2:0] HSIZE_BYTE = 3'b000;
    localparam logic [2:0] HSIZE_HALF = 3'b001;
    localparam logic [2:0] HSIZE_WORD = 3'b010;

    // hprot bit 0 marks a data access
    localparam logic [3:0] HPROT_DATA = 4'b0001;

    typedef enum logic [3:0] {
        LB, LH, LW, LBU, LHU, SB, SH, SW
    } lsu_op_e;

    typedef enum logic [1:0] {
        IDLE, READ, WRITE, READ_WAIT
    } ahb_state_e;

    // memory stage request
    typedef struct packed {
        logic        re;
        logic        we;
        lsu_op_e     op;
        logic [31:0] addr;
        logic [31:0] wdata;
    } lsu_req_t;

    // request after lane placement
    typedef struct packed {
        logic        re;
        logic        we;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [2:0]  size;
    } ahb_req_t;

    typedef struct packed {
        logic        hsel;
        logic [1:0]  htrans;
        logic [31:0] haddr;
        logic        hwrite;
        logic [2:0]  hsize;
        logic [2:0]  hburst;
        logic [3:0]  hprot;
        logic        hmastlock;
        logic [31:0] hwdata;
    } ahb_mst_t;

endpackage

// File: logic/mem_stall_ctrl.sv
`timescale 1ns/100ps

module mem_stall_ctrl import lsu_bus_pkg::*; (
    input  logic               mem_stallreq_i,
    input  logic               if_stallreq_i,
    input  logic               hold_i,
    output logic [STALL_W-1:0] stall_o
);

    // bits 0 up to the requesting stage
    function automatic logic [STALL_W-1:0] thermo(input int stage);
        logic [STALL_W-1:0] mask;
        mask = '0;
        for (int i = 0; i < STALL_W; i++) begin
            if (i <= stage) begin
                mask[i] = 1'b1;
            end
        end
        return mask;
    endfunction

    // deepest request wins, hold freezes everything
    always_comb begin
        if (hold_i) begin
            stall_o = '1;
        end else if (mem_stallreq_i) begin
            stall_o = thermo(MEM_STAGE);
        end else if (if_stallreq_i) begin
            stall_o = thermo(FETCH_STAGE);
        end else begin
            stall_o = '0;
        end
    end

endmodule

// File: verilog.f
logic/lsu_bus_pkg.sv
logic/lsu_align.sv
logic/ls_ahb_master.sv
logic/ahb_sram_slave.sv
logic/mem_stall_ctrl.sv
logic/lsu_ahb_top.sv
dv/tb_lsu_ahb.sv
